//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu16Tb
FILELIST  ?= cpu16.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without completing, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cpu16.f
+incdir+rtl
rtl/cpu16Pkg.sv
rtl/instrDecode.sv
rtl/aluExecute.sv
rtl/regFile.sv
rtl/resultSelect.sv
rtl/dataMemory.sv
rtl/cpu16Top.sv
verif/cpu16Tb.sv

//--- rtl/aluExecute.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module aluExecute import cpu16Pkg::*; (
	input  logic                         clk50Mhz,
	input  logic                         rstN,
	input  logic [`CPU16_DATA_WIDTH-1:0] aVal,
	input  logic [`CPU16_DATA_WIDTH-1:0] bVal,
	input  aluOp_e                       aluOp,
	input  logic                         flagWrite,
	output logic [`CPU16_DATA_WIDTH-1:0] aluResult,
	output logic [`CPU16_DATA_WIDTH-1:0] incResult,
	output logic [`CPU16_DATA_WIDTH-1:0] decResult,
	output logic [3:0]                   flags
);

	localparam int MSB = `CPU16_DATA_WIDTH - 1;

	logic [`CPU16_DATA_WIDTH:0] sumWide;
	logic [`CPU16_DATA_WIDTH:0] diffWide;
	logic [`CPU16_DATA_WIDTH:0] incWide;
	logic [`CPU16_DATA_WIDTH:0] decWide;
	logic                       carry;
	logic                       overflow;
	logic [3:0]                 flagsNext;

	// Extra top bit gives carry out, or borrow for the subtractors
	assign sumWide  = {1'b0, aVal} + {1'b0, bVal};
	assign diffWide = {1'b0, aVal} - {1'b0, bVal};
	assign incWide  = {1'b0, bVal} + 1'b1;
	assign decWide  = {1'b0, bVal} - 1'b1;

	assign incResult = incWide[MSB:0];
	assign decResult = decWide[MSB:0];

	//////////////////////////////////////////////////
	// Operation, carry and overflow
	//////////////////////////////////////////////////
	always_comb begin
		aluResult = bVal;
		carry     = 1'b0;
		overflow  = 1'b0;
		case (aluOp)
			aluAdd: begin
				aluResult = sumWide[MSB:0];
				carry     = sumWide[MSB+1];
				overflow  = (aVal[MSB] == bVal[MSB]) && (aluResult[MSB] != aVal[MSB]);
			end
			aluSub: begin
				aluResult = diffWide[MSB:0];
				carry     = diffWide[MSB+1];
				overflow  = (aVal[MSB] != bVal[MSB]) && (aluResult[MSB] != aVal[MSB]);
			end
			aluAnd: aluResult = aVal & bVal;
			aluOr:  aluResult = aVal | bVal;
			aluXor: aluResult = aVal ^ bVal;
			// Shift operand is rs, the bit out lands in carry
			aluShl: begin
				aluResult = {bVal[MSB-1:0], 1'b0};
				carry     = bVal[MSB];
			end
			aluInc: begin
				aluResult = incResult;
				carry     = incWide[MSB+1];
				overflow  = ~bVal[MSB] & incResult[MSB];
			end
			aluDec: begin
				aluResult = decResult;
				carry     = decWide[MSB+1];
				overflow  = bVal[MSB] & ~decResult[MSB];
			end
			default: aluResult = bVal;
		endcase
	end

	always_comb begin
		flagsNext         = '0;
		flagsNext[FLAG_Z] = (aluResult == '0);
		flagsNext[FLAG_N] = aluResult[MSB];
		flagsNext[FLAG_C] = carry;
		flagsNext[FLAG_V] = overflow;
	end

	// Flag register
	always_ff @(posedge clk50Mhz or negedge rstN) begin
		if (!rstN)
			flags <= '0;
		else if (flagWrite)
			flags <= flagsNext;
	end

endmodule

//--- rtl/cpu16Pkg.sv
package cpu16Pkg;

	//////////////////////////////////////////////////
	// Instruction opcodes, bits 17:14
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		opNop = 4'd0,
		opAdd = 4'd1,
		opSub = 4'd2,
		opAnd = 4'd3,
		opOr  = 4'd4,
		opXor = 4'd5,
		opShl = 4'd6,
		opXch = 4'd7,
		opMov = 4'd8,
		opLdi = 4'd9,
		opInc = 4'd10,
		opDec = 4'd11,
		opCmp = 4'd12,
		opLd  = 4'd13,
		opSt  = 4'd14,
		opBr  = 4'd15
	} opcode_e;

	// ALU operations; inc and dec only steer the flag logic
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShl,
		aluPass,
		aluInc,
		aluDec
	} aluOp_e;

	// Branch conditions carried in the rd field; other codes never branch
	typedef enum logic [3:0] {
		brAlways   = 4'd0,
		brZero     = 4'd1,
		brNotZero  = 4'd2,
		brCarry    = 4'd3,
		brNegative = 4'd4
	} brCond_e;

	// Source of the first write bus
	typedef enum logic [2:0] {
		wbAlu,
		wbInc,
		wbDec,
		wbMem,
		wbImm,
		wbB
	} wbSel_e;

	// Bit positions in the flag word
	localparam int FLAG_Z = 0;
	localparam int FLAG_N = 1;
	localparam int FLAG_C = 2;
	localparam int FLAG_V = 3;

endpackage

//--- rtl/cpu16Top.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module cpu16Top import cpu16Pkg::*; (
	input  logic                              clk50Mhz,
	input  logic                              rstN,
	input  logic [`CPU16_INSTR_WIDTH-1:0]     instrData,
	output logic [`CPU16_DATA_WIDTH-1:0]      instrAddr,
	output logic                              wbEn,
	output logic [`CPU16_REG_SEL_WIDTH-1:0]   wbAddr,
	output logic [`CPU16_DATA_WIDTH-1:0]      wbData,
	output logic                              wb2En,
	output logic [`CPU16_REG_SEL_WIDTH-1:0]   wb2Addr,
	output logic [`CPU16_DATA_WIDTH-1:0]      wb2Data,
	output logic                              stEn,
	output logic [`CPU16_DMEM_ADDR_WIDTH-1:0] stAddr,
	output logic [`CPU16_DATA_WIDTH-1:0]      stData,
	output logic [3:0]                        flags
);

	// Decode outputs
	aluOp_e                          aluOp;
	wbSel_e                          wbSel;
	logic [`CPU16_REG_SEL_WIDTH-1:0] aSel;
	logic [`CPU16_REG_SEL_WIDTH-1:0] bSel;
	logic                            decWbEn;
	logic                            decWb2En;
	logic                            decStEn;
	logic                            flagWrite;
	logic                            branchTaken;
	logic [`CPU16_DATA_WIDTH-1:0]    imm;

	// Datapath
	logic [`CPU16_DATA_WIDTH-1:0] aVal;
	logic [`CPU16_DATA_WIDTH-1:0] bVal;
	logic [`CPU16_DATA_WIDTH-1:0] aluResult;
	logic [`CPU16_DATA_WIDTH-1:0] incResult;
	logic [`CPU16_DATA_WIDTH-1:0] decResult;
	logic [`CPU16_DATA_WIDTH-1:0] memData;

	//////////////////////////////////////////////////
	// Strobes held off while in reset
	//////////////////////////////////////////////////
	assign wbEn  = decWbEn & rstN;
	assign wb2En = decWb2En & rstN;
	assign stEn  = decStEn & rstN;

	// Memory is addressed by rs and stores rd
	assign stAddr = bVal[`CPU16_DMEM_ADDR_WIDTH-1:0];
	assign stData = aVal;

	instrDecode u_decode (
		.instrData(instrData), .flags(flags), .aluOp(aluOp),
		.aSel(aSel), .bSel(bSel), .dest(wbAddr), .dest2(wb2Addr),
		.wbSel(wbSel), .wbEn(decWbEn), .wb2En(decWb2En), .flagWrite(flagWrite),
		.stEn(decStEn), .branchTaken(branchTaken), .imm(imm)
	);

	regFile u_regs (
		.clk50Mhz(clk50Mhz), .rstN(rstN), .aSel(aSel), .bSel(bSel),
		.dest(wbAddr), .dest2(wb2Addr), .wbEn(wbEn), .wb2En(wb2En),
		.wbData(wbData), .wb2Data(wb2Data), .aVal(aVal), .bVal(bVal)
	);

	aluExecute u_alu (
		.clk50Mhz(clk50Mhz), .rstN(rstN), .aVal(aVal), .bVal(bVal),
		.aluOp(aluOp), .flagWrite(flagWrite), .aluResult(aluResult),
		.incResult(incResult), .decResult(decResult), .flags(flags)
	);

	resultSelect u_result (
		.clk50Mhz(clk50Mhz), .rstN(rstN), .wbSel(wbSel), .aVal(aVal), .bVal(bVal),
		.aluResult(aluResult), .incResult(incResult), .decResult(decResult),
		.memData(memData), .imm(imm), .branchTaken(branchTaken),
		.wbData(wbData), .wb2Data(wb2Data), .pc(instrAddr)
	);

	dataMemory u_dmem (
		.clk50Mhz(clk50Mhz), .wrEn(stEn), .addr(stAddr),
		.wrData(stData), .rdData(memData)
	);

endmodule

//--- rtl/cpu16_config.svh
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data word, also the width of pc
`define CPU16_DATA_WIDTH 16

// Opcode, rd, rs and the immediate share this word
`define CPU16_INSTR_WIDTH 18

// Low bits of the instruction used as immediate or branch offset
`define CPU16_IMM_WIDTH 10

//////////////////////////////////////////////////
// Storage sizes
//////////////////////////////////////////////////

`define CPU16_REG_COUNT 16
`define CPU16_REG_SEL_WIDTH 4

// Word-addressed data RAM
`define CPU16_DMEM_DEPTH 256
`define CPU16_DMEM_ADDR_WIDTH $clog2(`CPU16_DMEM_DEPTH)

`endif

//--- rtl/dataMemory.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module dataMemory (
	input  logic                             clk50Mhz,
	input  logic                             wrEn,
	input  logic [`CPU16_DMEM_ADDR_WIDTH-1:0] addr,
	input  logic [`CPU16_DATA_WIDTH-1:0]     wrData,
	output logic [`CPU16_DATA_WIDTH-1:0]     rdData
);

	logic [`CPU16_DATA_WIDTH-1:0] mem [`CPU16_DMEM_DEPTH];

	//////////////////////////////////////////////////
	// Single address shared by load and store
	//////////////////////////////////////////////////

	// Read follows the address within the cycle
	assign rdData = mem[addr];

	always_ff @(posedge clk50Mhz) begin
		if (wrEn)
			mem[addr] <= wrData;
	end

endmodule

//--- rtl/instrDecode.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module instrDecode import cpu16Pkg::*; (
	input  logic [`CPU16_INSTR_WIDTH-1:0]   instrData,
	input  logic [3:0]                      flags,
	output aluOp_e                          aluOp,
	output logic [`CPU16_REG_SEL_WIDTH-1:0] aSel,
	output logic [`CPU16_REG_SEL_WIDTH-1:0] bSel,
	output logic [`CPU16_REG_SEL_WIDTH-1:0] dest,
	output logic [`CPU16_REG_SEL_WIDTH-1:0] dest2,
	output wbSel_e                          wbSel,
	output logic                            wbEn,
	output logic                            wb2En,
	output logic                            flagWrite,
	output logic                            stEn,
	output logic                            branchTaken,
	output logic [`CPU16_DATA_WIDTH-1:0]    imm
);

	opcode_e                       opcode;
	brCond_e                       cond;
	logic [`CPU16_IMM_WIDTH-1:0]   immField;
	logic                          condMet;

	// Field split
	assign opcode   = opcode_e'(instrData[17:14]);
	assign cond     = brCond_e'(instrData[13:10]);
	assign immField = instrData[`CPU16_IMM_WIDTH-1:0];

	// rd reads on port a, rs on port b; XCH writes rs back through port 2
	assign aSel  = instrData[13:10];
	assign bSel  = instrData[9:6];
	assign dest  = instrData[13:10];
	assign dest2 = instrData[9:6];

	// Branch offset is signed, LDI value is not
	assign imm = (opcode == opBr) ?
		{{(`CPU16_DATA_WIDTH-`CPU16_IMM_WIDTH){immField[`CPU16_IMM_WIDTH-1]}}, immField} :
		{{(`CPU16_DATA_WIDTH-`CPU16_IMM_WIDTH){1'b0}}, immField};

	//////////////////////////////////////////////////
	// Branch condition against the registered flags
	//////////////////////////////////////////////////
	always_comb begin
		case (cond)
			brAlways:   condMet = 1'b1;
			brZero:     condMet = flags[FLAG_Z];
			brNotZero:  condMet = ~flags[FLAG_Z];
			brCarry:    condMet = flags[FLAG_C];
			brNegative: condMet = flags[FLAG_N];
			default:    condMet = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// Opcode to control strobes
	//////////////////////////////////////////////////
	always_comb begin
		aluOp       = aluPass;
		wbSel       = wbAlu;
		wbEn        = 1'b0;
		wb2En       = 1'b0;
		flagWrite   = 1'b0;
		stEn        = 1'b0;
		branchTaken = 1'b0;

		case (opcode)
			opAdd, opSub, opAnd, opOr, opXor, opShl: begin
				case (opcode)
					opAdd:   aluOp = aluAdd;
					opSub:   aluOp = aluSub;
					opAnd:   aluOp = aluAnd;
					opOr:    aluOp = aluOr;
					opXor:   aluOp = aluXor;
					default: aluOp = aluShl;
				endcase
				wbEn      = 1'b1;
				flagWrite = 1'b1;
			end
			// Both ports write, rd gets rs and rs gets rd
			opXch: begin
				wbSel = wbB;
				wbEn  = 1'b1;
				wb2En = 1'b1;
			end
			opMov: begin
				wbSel = wbB;
				wbEn  = 1'b1;
			end
			opLdi: begin
				wbSel = wbImm;
				wbEn  = 1'b1;
			end
			opInc: begin
				aluOp     = aluInc;
				wbSel     = wbInc;
				wbEn      = 1'b1;
				flagWrite = 1'b1;
			end
			opDec: begin
				aluOp     = aluDec;
				wbSel     = wbDec;
				wbEn      = 1'b1;
				flagWrite = 1'b1;
			end
			// Subtract for flags only
			opCmp: begin
				aluOp     = aluSub;
				flagWrite = 1'b1;
			end
			opLd: begin
				wbSel = wbMem;
				wbEn  = 1'b1;
			end
			opSt:    stEn = 1'b1;
			opBr:    branchTaken = condMet;
			default: ;
		endcase
	end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module regFile (
	input  logic                            clk50Mhz,
	input  logic                            rstN,
	input  logic [`CPU16_REG_SEL_WIDTH-1:0] aSel,
	input  logic [`CPU16_REG_SEL_WIDTH-1:0] bSel,
	input  logic [`CPU16_REG_SEL_WIDTH-1:0] dest,
	input  logic [`CPU16_REG_SEL_WIDTH-1:0] dest2,
	input  logic                            wbEn,
	input  logic                            wb2En,
	input  logic [`CPU16_DATA_WIDTH-1:0]    wbData,
	input  logic [`CPU16_DATA_WIDTH-1:0]    wb2Data,
	output logic [`CPU16_DATA_WIDTH-1:0]    aVal,
	output logic [`CPU16_DATA_WIDTH-1:0]    bVal
);

	logic [`CPU16_DATA_WIDTH-1:0] regs [`CPU16_REG_COUNT];

	//////////////////////////////////////////////////
	// Read ports, combinational
	//////////////////////////////////////////////////
	assign aVal = regs[aSel];
	assign bVal = regs[bSel];

	//////////////////////////////////////////////////
	// Write ports
	//////////////////////////////////////////////////
	always_ff @(posedge clk50Mhz or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU16_REG_COUNT; i++)
				regs[i] <= '0;
		end else begin
			if (wbEn)
				regs[dest] <= wbData;
			// Second port last, so it wins on XCH of a register with itself
			if (wb2En)
				regs[dest2] <= wb2Data;
		end
	end

endmodule

//--- rtl/resultSelect.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module resultSelect import cpu16Pkg::*; (
	input  logic                         clk50Mhz,
	input  logic                         rstN,
	input  wbSel_e                       wbSel,
	input  logic [`CPU16_DATA_WIDTH-1:0] aVal,
	input  logic [`CPU16_DATA_WIDTH-1:0] bVal,
	input  logic [`CPU16_DATA_WIDTH-1:0] aluResult,
	input  logic [`CPU16_DATA_WIDTH-1:0] incResult,
	input  logic [`CPU16_DATA_WIDTH-1:0] decResult,
	input  logic [`CPU16_DATA_WIDTH-1:0] memData,
	input  logic [`CPU16_DATA_WIDTH-1:0] imm,
	input  logic                         branchTaken,
	output logic [`CPU16_DATA_WIDTH-1:0] wbData,
	output logic [`CPU16_DATA_WIDTH-1:0] wb2Data,
	output logic [`CPU16_DATA_WIDTH-1:0] pc
);

	logic [`CPU16_DATA_WIDTH-1:0] pcPlus1;
	logic [`CPU16_DATA_WIDTH-1:0] pcNext;

	//////////////////////////////////////////////////
	// Write-back buses
	//////////////////////////////////////////////////
	always_comb begin
		case (wbSel)
			wbAlu:   wbData = aluResult;
			wbInc:   wbData = incResult;
			wbDec:   wbData = decResult;
			wbMem:   wbData = memData;
			wbImm:   wbData = imm;
			wbB:     wbData = bVal;
			default: wbData = aluResult;
		endcase
	end

	// Old rd value goes back to rs on an exchange
	assign wb2Data = aVal;

	//////////////////////////////////////////////////
	// Program counter
	//////////////////////////////////////////////////
	assign pcPlus1 = pc + 1'b1;

	// Offset is relative to the following instruction
	assign pcNext = branchTaken ? (pcPlus1 + imm) : pcPlus1;

	always_ff @(posedge clk50Mhz or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else
			pc <= pcNext;
	end

endmodule

//--- verif/cpu16Tb.sv
`timescale 1ns/1ps
`include "cpu16_config.svh"

module cpu16Tb import cpu16Pkg::*; ();

	localparam int CLK_PERIOD      = 10;
	localparam int DRIVE_DELAY     = 1;
	localparam int RESET_CYCLES    = 4;
	localparam int PROG_LEN        = 64;
	// LDI, then a store and an increment per data word
	localparam int FILL_LEN        = 1 + 2 * `CPU16_DMEM_DEPTH;
	localparam int RUN_LEN         = 2000;
	localparam int TOTAL_INSTR     = FILL_LEN + RUN_LEN;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_INSTR + 100;
	localparam logic [31:0] SEED   = 32'h035d_ab84;

	// Expected outcome of one instruction
	typedef struct packed {
		logic                              wbEn;
		logic [`CPU16_REG_SEL_WIDTH-1:0]   wbAddr;
		logic [`CPU16_DATA_WIDTH-1:0]      wbData;
		logic                              wb2En;
		logic [`CPU16_REG_SEL_WIDTH-1:0]   wb2Addr;
		logic [`CPU16_DATA_WIDTH-1:0]      wb2Data;
		logic                              stEn;
		logic [`CPU16_DMEM_ADDR_WIDTH-1:0] stAddr;
		logic [`CPU16_DATA_WIDTH-1:0]      stData;
		logic [3:0]                        flags;
		logic [`CPU16_DATA_WIDTH-1:0]      nextPc;
	} stepResult_t;

	logic                              clk50Mhz = 1'b0;
	logic                              rstN;
	logic [`CPU16_INSTR_WIDTH-1:0]     instrData;
	logic [`CPU16_DATA_WIDTH-1:0]      instrAddr;
	logic                              wbEn;
	logic [`CPU16_REG_SEL_WIDTH-1:0]   wbAddr;
	logic [`CPU16_DATA_WIDTH-1:0]      wbData;
	logic                              wb2En;
	logic [`CPU16_REG_SEL_WIDTH-1:0]   wb2Addr;
	logic [`CPU16_DATA_WIDTH-1:0]      wb2Data;
	logic                              stEn;
	logic [`CPU16_DMEM_ADDR_WIDTH-1:0] stAddr;
	logic [`CPU16_DATA_WIDTH-1:0]      stData;
	logic [3:0]                        flags;

	// Architectural state of the model
	logic [`CPU16_DATA_WIDTH-1:0]  modelRegs [`CPU16_REG_COUNT];
	logic [`CPU16_DATA_WIDTH-1:0]  modelMem [`CPU16_DMEM_DEPTH];
	logic [3:0]                    modelFlags;
	logic [`CPU16_DATA_WIDTH-1:0]  modelPc;
	logic [`CPU16_INSTR_WIDTH-1:0] progMem [PROG_LEN];
	logic [`CPU16_INSTR_WIDTH-1:0] curInstr;
	stepResult_t                   predicted;
	logic [31:0]                   rngState;
	int                            checkedCount;

	cpu16Top u_dut (
		.clk50Mhz(clk50Mhz), .rstN(rstN), .instrData(instrData), .instrAddr(instrAddr),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.wb2En(wb2En), .wb2Addr(wb2Addr), .wb2Data(wb2Data),
		.stEn(stEn), .stAddr(stAddr), .stData(stData), .flags(flags)
	);

	always #(CLK_PERIOD / 2) clk50Mhz = ~clk50Mhz;

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [`CPU16_INSTR_WIDTH-1:0] randomInstr(input logic [31:0] r);
		logic [3:0] cond;
		int         offset;
		if (r[31:28] != opBr)
			return {r[31:28], r[13:0]};
		// Codes 0 to 4 test a flag and code 5 never branches
		cond   = r[3:0] % 4'd6;
		offset = int'(r[8:4]) % 17 - 8;
		// Backward unconditional jumps would trap the run in a loop
		if (cond == 4'd0 && offset < 0)
			offset = -offset;
		return {opBr, cond, 10'(offset)};
	endfunction

	// Fill program that leaves mem[a] = a for every address
	function automatic logic [`CPU16_INSTR_WIDTH-1:0] fillWord(input int n);
		if (n == 0)
			return {opLdi, 4'd1, 10'd0};
		else if (n % 2 == 1)
			return {opSt, 4'd1, 4'd1, 6'd0};
		return {opInc, 4'd1, 4'd1, 6'd0};
	endfunction

	function automatic logic [`CPU16_INSTR_WIDTH-1:0] fetchWord(input int count,
			input logic [`CPU16_DATA_WIDTH-1:0] addr);
		if (count < FILL_LEN)
			return fillWord(count);
		return progMem[addr[5:0]];
	endfunction

	//////////////////////////////////////////////////
	// ISA reference model
	//////////////////////////////////////////////////
	function automatic logic signedOverflow(input int value);
		return (value > 32767) || (value < -32768);
	endfunction

	function automatic stepResult_t predictStep(input logic [`CPU16_INSTR_WIDTH-1:0] instr);
		stepResult_t r;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		int          ua;
		int          ub;
		int          sa;
		int          sb;
		logic        updFlags;
		logic        cFlag;
		logic        vFlag;
		logic        taken;

		rd       = instr[13:10];
		rs       = instr[9:6];
		a        = modelRegs[rd];
		b        = modelRegs[rs];
		ua       = int'(a);
		ub       = int'(b);
		sa       = int'($signed(a));
		sb       = int'($signed(b));
		res      = '0;
		updFlags = 1'b1;
		cFlag    = 1'b0;
		vFlag    = 1'b0;
		taken    = 1'b0;
		r        = '0;
		r.flags  = modelFlags;
		r.nextPc = modelPc + 16'd1;

		case (instr[17:14])
			opAdd: begin
				res   = a + b;
				cFlag = (ua + ub) > 65535;
				vFlag = signedOverflow(sa + sb);
			end
			// CMP computes like SUB but writes nothing
			opSub, opCmp: begin
				res   = a - b;
				cFlag = ua < ub;
				vFlag = signedOverflow(sa - sb);
			end
			opAnd: res = a & b;
			opOr:  res = a | b;
			opXor: res = a ^ b;
			opShl: begin
				res   = {b[14:0], 1'b0};
				cFlag = b[15];
			end
			opInc: begin
				res   = b + 16'd1;
				cFlag = (ub == 65535);
				vFlag = signedOverflow(sb + 1);
			end
			opDec: begin
				res   = b - 16'd1;
				cFlag = (ub == 0);
				vFlag = signedOverflow(sb - 1);
			end
			default: updFlags = 1'b0;
		endcase

		r.wbAddr  = rd;
		r.wb2Addr = rs;
		case (instr[17:14])
			opNop, opCmp: ;
			opXch: begin
				r.wbEn    = 1'b1;
				r.wbData  = b;
				r.wb2En   = 1'b1;
				r.wb2Data = a;
			end
			opMov: begin
				r.wbEn   = 1'b1;
				r.wbData = b;
			end
			opLdi: begin
				r.wbEn   = 1'b1;
				r.wbData = {6'd0, instr[9:0]};
			end
			opLd: begin
				r.wbEn   = 1'b1;
				r.wbData = modelMem[b[`CPU16_DMEM_ADDR_WIDTH-1:0]];
			end
			opSt: begin
				r.stEn   = 1'b1;
				r.stAddr = b[`CPU16_DMEM_ADDR_WIDTH-1:0];
				r.stData = a;
			end
			opBr: begin
				case (rd)
					4'd0:    taken = 1'b1;
					4'd1:    taken = modelFlags[FLAG_Z];
					4'd2:    taken = ~modelFlags[FLAG_Z];
					4'd3:    taken = modelFlags[FLAG_C];
					4'd4:    taken = modelFlags[FLAG_N];
					default: taken = 1'b0;
				endcase
				if (taken)
					r.nextPc = modelPc + 16'd1 + {{6{instr[9]}}, instr[9:0]};
			end
			default: begin
				r.wbEn   = 1'b1;
				r.wbData = res;
			end
		endcase

		if (updFlags) begin
			r.flags[FLAG_Z] = (res == 16'd0);
			r.flags[FLAG_N] = res[15];
			r.flags[FLAG_C] = cFlag;
			r.flags[FLAG_V] = vFlag;
		end
		return r;
	endfunction

	task automatic commitStep(input stepResult_t r);
		if (r.wbEn)
			modelRegs[r.wbAddr] = r.wbData;
		// Second port last as in the register file
		if (r.wb2En)
			modelRegs[r.wb2Addr] = r.wb2Data;
		if (r.stEn)
			modelMem[r.stAddr] = r.stData;
		modelFlags = r.flags;
		modelPc    = r.nextPc;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: actual 0x%0h, expected 0x%0h at %0t",
				name, actual, expected, $time);
			$display("sim failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// Reset, program and instruction fetch
	//////////////////////////////////////////////////
	initial begin
		rstN         = 1'b0;
		// Exchange during reset with all enables held low
		instrData    = {opXch, 4'd1, 4'd2, 6'd0};
		modelFlags   = '0;
		modelPc      = '0;
		checkedCount = 0;
		for (int i = 0; i < `CPU16_REG_COUNT; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < `CPU16_DMEM_DEPTH; i++)
			modelMem[i] = '0;
		rngState = SEED;
		for (int i = 0; i < PROG_LEN; i++) begin
			rngState   = xorshift32(rngState);
			progMem[i] = randomInstr(rngState);
		end
		// Store then load through the same rs
		progMem[20] = {opSt, 4'd3, 4'd4, 6'd0};
		progMem[21] = {opLd, 4'd5, 4'd4, 6'd0};

		repeat (RESET_CYCLES / 2) @(posedge clk50Mhz);
		#DRIVE_DELAY;
		instrData = {opSt, 4'd2, 4'd3, 6'd0};
		repeat (RESET_CYCLES / 2) @(posedge clk50Mhz);
		#DRIVE_DELAY;
		rstN = 1'b1;
		for (int n = 0; n < TOTAL_INSTR; n++) begin
			instrData = fetchWord(n, instrAddr);
			@(posedge clk50Mhz);
			#DRIVE_DELAY;
		end

		// Flags and pc left by the last instruction
		checkValue("flags", 32'(flags), 32'(modelFlags));
		checkValue("instrAddr", 32'(instrAddr), 32'(modelPc));
		$display("sim passed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Comparison at mid cycle with settled outputs
	//////////////////////////////////////////////////
	always @(negedge clk50Mhz) begin
		if (!rstN) begin
			checkValue("instrAddr", 32'(instrAddr), 32'd0);
			checkValue("wbEn", 32'(wbEn), 32'd0);
			checkValue("wb2En", 32'(wb2En), 32'd0);
			checkValue("stEn", 32'(stEn), 32'd0);
			checkValue("flags", 32'(flags), 32'd0);
		end else if (checkedCount < TOTAL_INSTR) begin
			curInstr  = fetchWord(checkedCount, modelPc);
			predicted = predictStep(curInstr);
			checkValue("instrAddr", 32'(instrAddr), 32'(modelPc));
			checkValue("flags", 32'(flags), 32'(modelFlags));
			checkValue("wbEn", 32'(wbEn), 32'(predicted.wbEn));
			checkValue("wb2En", 32'(wb2En), 32'(predicted.wb2En));
			checkValue("stEn", 32'(stEn), 32'(predicted.stEn));
			if (predicted.wbEn) begin
				checkValue("wbAddr", 32'(wbAddr), 32'(predicted.wbAddr));
				checkValue("wbData", 32'(wbData), 32'(predicted.wbData));
			end
			if (predicted.wb2En) begin
				checkValue("wb2Addr", 32'(wb2Addr), 32'(predicted.wb2Addr));
				checkValue("wb2Data", 32'(wb2Data), 32'(predicted.wb2Data));
			end
			if (predicted.stEn) begin
				checkValue("stAddr", 32'(stAddr), 32'(predicted.stAddr));
				checkValue("stData", 32'(stData), 32'(predicted.stData));
			end
			commitStep(predicted);
			checkedCount++;
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1, "Timeout");
	end

endmodule
